// ==== decodeGolden.txt ====
# word0 word1, then per lane: alu flags(selA selB memEn memRead memWrite memToReg cp0 hilo regWen
# masterOnly) exc(undef syscall break eret spec) branch link waddr(dec) immExt, then dualIssue
00221820 00853022 07 0000000010 00000 0 0 03 00001820 09 0000000010 00000 0 0 06 00003022 1
00023900 00220018 0b 1000000010 00000 0 0 07 00003900 11 0000000101 00000 0 0 00 00000018 0
00004010 70224802 15 0000000011 00000 0 0 08 00004010 11 0000000011 00000 0 0 09 00004802 0
70220000 716a5020 1b 0000000101 00000 0 0 00 00000000 1a 0000000011 00000 0 0 10 00005020 0
8fa5fffc aca60008 08 0111010010 00000 0 0 05 fffffffc 08 0110100000 00000 0 0 00 00000008 0
80628000 a0e40010 08 0111010010 00000 0 0 02 ffff8000 08 0110100000 00000 0 0 00 00000010 1
2128ffff 316affff 07 0100000010 00000 0 0 08 ffffffff 01 0100000010 00000 0 0 10 0000ffff 1
3c0c8001 358d8000 1f 0100000010 00000 0 0 12 00008001 02 0100000010 00000 0 0 13 00008000 0
2841fffe 38838000 05 0100000010 00000 0 0 01 fffffffe 03 0100000010 00000 0 0 03 00008000 1
08000100 00641021 00 0000000000 00000 1 0 00 00000100 08 0000000010 00000 0 0 02 00001021 0
0c000040 03e00008 00 0000000010 00000 1 1 31 00000040 00 0000000000 00000 2 0 00 00000008 0
00c02809 1022fffe 00 0000000010 00000 2 1 05 00002809 00 0000000000 00000 3 0 31 fffffffe 0
04900010 04a10020 00 0000000010 00000 8 1 31 00000010 00 0000000000 00000 7 0 00 00000020 0
14200008 04f1fff0 00 0000000000 00000 4 0 00 00000008 00 0000000010 00000 7 1 31 fffffff0 0
18400004 1c600004 00 0000000000 00000 6 0 00 00000004 00 0000000000 00000 5 0 00 00000004 0
40046000 40856800 20 0000000010 00001 0 0 04 00006000 21 0000001000 00001 0 0 13 00006800 0
42000018 0000000c 00 0000000000 00011 0 0 00 00000018 00 0000000000 01001 0 0 00 0000000c 0
0000000d fc000000 00 0000000000 00101 0 0 00 0000000d 00 0000000000 10000 0 0 00 00000000 0
0043080b 00220030 00 0000000000 10000 0 0 01 0000080b 00 0000000000 10000 0 0 00 00000030 0
00220021 00002025 08 0000000010 00000 0 0 00 00000021 02 0000000010 00000 0 0 04 00002025 1
00224825 ac690000 02 0000000010 00000 0 0 09 00004825 08 0110100000 00000 0 0 00 00000000 0
00220018 00851827 11 0000000101 00000 0 0 00 00000018 04 0000000010 00000 0 0 03 00001827 1
00031043 00c7282b 0f 1000000010 00000 0 0 02 00001043 06 0000000010 00000 0 0 05 0000282b 1
00800013 00620806 18 0000000101 00000 0 0 00 00000013 0e 0000000010 00000 0 0 01 00000806 1

// ==== sim.f ====
mipsPkg.sv
instrLatch.sv
ctrlDecode.sv
decodeLane.sv
issuePair.sv
mipsDecodeUnit.sv
tbMipsDecodeUnit.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the decode unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sim.f --top-module tbMipsDecodeUnit -o simv; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/simv; then
    echo "simulation failed"
    exit 1
fi

exit 0

// ==== tbMipsDecodeUnit.sv ====
`timescale 1ns/1ps

module tbMipsDecodeUnit import mipsPkg::*; ();

    logic        clk;
    logic        rstN;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic        wbAdr;
    logic [31:0] wbDat;
    logic        wbAck;
    logic        outReady;
    logic        outValid;
    packetPair   outPackets;
    logic        dualIssue;

    logic [31:0] word0[$];
    logic [31:0] word1[$];
    decodedInstr exp0[$];
    decodedInstr exp1[$];
    logic        expDual[$];

    int          numPairs;
    int          committed;
    int          received;
    int          cycles;
    int          cycleLimit;
    logic        started;
    logic        holdPrev;   // output stalled across the coming rising edge
    packetPair   prevPackets;
    logic        prevDual;

    mipsDecodeUnit u_mipsDecodeUnit (
        .clk       (clk),
        .rstN      (rstN),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDat     (wbDat),
        .wbAck     (wbAck),
        .outReady  (outReady),
        .outValid  (outValid),
        .outPackets(outPackets),
        .dualIssue (dualIssue)
    );

    always #20 clk = ~clk;

    task automatic stopWithFail(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkVal(input string name, input logic [159:0] got,
                            input logic [159:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            stopWithFail("value mismatch");
        end
    endtask

    function automatic decodedInstr makePacket(input logic [31:0] word, input logic [7:0] alu,
                                               input logic [9:0] flags, input logic [4:0] exc,
                                               input logic [3:0] br, input logic link,
                                               input logic [4:0] waddr,
                                               input logic [31:0] imm);
        decodedInstr p;
        p.ctrl = {alu, flags};
        p.exc = exc;
        p.branch = br;
        p.linkPc8 = link;
        p.regWaddr = waddr;
        p.srcA = word[25:21];  // rs
        p.srcB = word[20:16];  // rt
        p.immExt = imm;
        return p;
    endfunction

    task automatic loadGolden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] w0, w1, imm0, imm1;
        logic [7:0]  alu0, alu1;
        logic [9:0]  fl0, fl1;
        logic [4:0]  ex0, ex1;
        logic [3:0]  br0, br1;
        logic        lk0, lk1, dual;
        int          wa0, wa1;
        fd = $fopen("decodeGolden.txt", "r");
        if (fd == 0)
            stopWithFail("cannot open decodeGolden.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 8 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %b %b %h %b %d %h %h %b %b %h %b %d %h %b",
                        w0, w1, alu0, fl0, ex0, br0, lk0, wa0, imm0,
                        alu1, fl1, ex1, br1, lk1, wa1, imm1, dual);
            if (n != 17)
                stopWithFail("malformed line in decodeGolden.txt");
            word0.push_back(w0);
            word1.push_back(w1);
            exp0.push_back(makePacket(w0, alu0, fl0, ex0, br0, lk0, wa0[4:0], imm0));
            exp1.push_back(makePacket(w1, alu1, fl1, ex1, br1, lk1, wa1[4:0], imm1));
            expDual.push_back(dual);
        end
        $fclose(fd);
        numPairs = word0.size();
    endtask

    task automatic wbCycle(input logic we, input logic adr, input logic [31:0] data);
        int waitCycles;
        @(negedge clk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDat = data;
        waitCycles = 0;
        @(negedge clk);
        while (!wbAck) begin
            waitCycles++;
            if (waitCycles >= 20)
                stopWithFail("wishbone cycle was not acknowledged within 20 cycles");
            @(negedge clk);
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
    endtask

    // cycle budget and in-flight bound
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit)
            stopWithFail("timeout, the run exceeded its cycle limit");
        if (committed - received > 2)
            stopWithFail("more than two pairs in flight, a commit was acked under stall");
    end

    // consumer with random stalls and a long stall every 20 cycles
    always @(negedge clk) begin
        if (started) begin
            if (holdPrev) begin
                checkVal("outValid", 160'(outValid), 160'(1'b1));
                checkVal("outPackets", 160'(outPackets), 160'(prevPackets));
                checkVal("dualIssue", 160'(dualIssue), 160'(prevDual));
            end
            outReady = ((cycles % 20) >= 10) && (($urandom % 3) != 0);
            // the transfer happens at the next rising edge
            if (outValid && outReady) begin
                if (received >= numPairs) begin
                    stopWithFail("an extra packet arrived after the last expected one");
                end else begin
                    checkVal("outPackets[0]", 160'(outPackets[0]), 160'(exp0[received]));
                    checkVal("outPackets[1]", 160'(outPackets[1]), 160'(exp1[received]));
                    checkVal("dualIssue", 160'(dualIssue), 160'(expDual[received]));
                    received++;
                end
            end
            holdPrev = outValid && !outReady;
            prevPackets = outPackets;
            prevDual = dualIssue;
        end
    end

    initial begin
        void'($urandom(32'h9f3c22c9));
        clk = 1'b0;
        rstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = 1'b0;
        wbDat = '0;
        outReady = 1'b0;
        committed = 0;
        received = 0;
        cycles = 0;
        cycleLimit = 1000;
        started = 1'b0;
        holdPrev = 1'b0;
        prevDual = 1'b0;
        prevPackets = '0;

        loadGolden();
        cycleLimit = 40 * numPairs;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkVal("wbAck", 160'(wbAck), 160'(1'b0));
        checkVal("outValid", 160'(outValid), 160'(1'b0));

        // a read is acked and leaves the pipeline empty
        wbCycle(1'b0, WB_ADR_LANE1, 32'h0);
        @(negedge clk);
        checkVal("outValid", 160'(outValid), 160'(1'b0));

        started = 1'b1;
        for (int i = 0; i < numPairs; i++) begin
            wbCycle(1'b1, WB_ADR_LANE0, word0[i]);
            wbCycle(1'b1, WB_ADR_LANE1, word1[i]);
            committed++;
        end
        while (received < numPairs)
            @(negedge clk);
        repeat (3) @(negedge clk);

        if (outValid === 1'b0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stopWithFail("a packet is still valid after the last expected one");
        end
    end

endmodule

// ==== mipsDecodeUnit.sv ====
`timescale 1ns/1ps

module mipsDecodeUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic        wbAdr,
    input  logic [31:0] wbDat,
    output logic        wbAck,
    input  logic        outReady,
    output logic        outValid,
    output packetPair   outPackets,
    output logic        dualIssue
);

    lanePair   lanes;
    packetPair packets;
    logic      pairValid;
    logic      pairTaken;

    instrLatch u_instrLatch (
        .clk      (clk),
        .rstN     (rstN),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDat    (wbDat),
        .wbAck    (wbAck),
        .pairTaken(pairTaken),
        .lanes    (lanes),
        .pairValid(pairValid)
    );

    // identical decoders, one per issue slot
    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        decodeLane u_decodeLane (
            .instr (lanes[i]),
            .packet(packets[i])
        );
    end

    issuePair u_issuePair (
        .clk       (clk),
        .rstN      (rstN),
        .packets   (packets),
        .pairValid (pairValid),
        .pairTaken (pairTaken),
        .outReady  (outReady),
        .outValid  (outValid),
        .outPackets(outPackets),
        .dualIssue (dualIssue)
    );

endmodule

// ==== issuePair.sv ====
`timescale 1ns/1ps

module issuePair import mipsPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  packetPair packets,
    input  logic      pairValid,
    output logic      pairTaken,
    input  logic      outReady,
    output logic      outValid,
    output packetPair outPackets,
    output logic      dualIssue
);

    decodedInstr lead;
    decodedInstr follow;
    logic        rawHazard;
    logic        dualNext;

    assign lead = packets[0];
    assign follow = packets[1];

    // lane 1 reads what lane 0 writes in the same cycle
    assign rawHazard = lead.ctrl.regWen && (lead.regWaddr != '0) &&
                       ((lead.regWaddr == follow.srcA) || (lead.regWaddr == follow.srcB));

    assign dualNext = !(follow.ctrl.masterOnly ||
                        (lead.branch != BT_NOP) ||  // delay slot goes alone
                        (|lead.exc) ||
                        rawHazard);

    assign pairTaken = pairValid && (!outValid || outReady);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (pairTaken) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pairTaken) begin
            outPackets <= packets;
            dualIssue <= dualNext;
        end
    end

endmodule

// ==== decodeLane.sv ====
`timescale 1ns/1ps

module decodeLane import mipsPkg::*; (
    input  instrWord    instr,
    output decodedInstr packet
);

    ctrlSign    ctrl;
    excFlags    exc;
    branchType  branch;
    logic       linkPc8;
    regIdx      waddr;
    logic [5:0] op;
    regIdx      rt;
    logic       isLinkRegimm;
    logic [31:0] immExt;

    assign op = instr.jFormat.op;
    assign rt = instr.iFormat.rt;
    assign isLinkRegimm = (rt == RT_BGEZAL) || (rt == RT_BLTZAL);
    // ANDI/ORI/XORI/LUI zero extend
    assign immExt = (op[3:2] == 2'b11) ? {16'h0, instr.iFormat.imm} :
                    {{16{instr.iFormat.imm[15]}}, instr.iFormat.imm};

    ctrlDecode u_ctrlDecode (
        .instr(instr),
        .ctrl (ctrl),
        .exc  (exc)
    );

    always_comb begin
        branch = BT_NOP;
        linkPc8 = 1'b0;
        case (op)
            OP_SPECIAL: begin
                if (instr.rFormat.funct == FUN_JR || instr.rFormat.funct == FUN_JALR)
                    branch = BT_JREG;
                linkPc8 = (instr.rFormat.funct == FUN_JALR);
            end
            OP_J: branch = BT_J;
            OP_JAL: begin
                branch = BT_J;
                linkPc8 = 1'b1;
            end
            OP_BEQ: branch = BT_BEQ;
            OP_BNE: branch = BT_BNE;
            OP_BGTZ: branch = BT_BGTZ;
            OP_BLEZ: branch = BT_BLEZ;
            OP_REGIMM: begin
                if (rt == RT_BGEZ || rt == RT_BGEZAL)
                    branch = BT_BGEZ;
                else if (rt == RT_BLTZ || rt == RT_BLTZAL)
                    branch = BT_BLTZ;
                linkPc8 = isLinkRegimm;
            end
            default: branch = BT_NOP;
        endcase
    end

    always_comb begin
        waddr = instr.rFormat.rd;
        case (op)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: waddr = rt;
            OP_JAL: waddr = LINK_REG;
            OP_REGIMM: if (isLinkRegimm) waddr = LINK_REG;
            OP_COP0: if (instr.rFormat.rs == RS_MFC0) waddr = rt;  // mfc0 writes rt
            default: waddr = instr.rFormat.rd;
        endcase
    end

    assign packet = '{ctrl: ctrl, exc: exc, branch: branch, linkPc8: linkPc8,
                      regWaddr: waddr, srcA: instr.rFormat.rs, srcB: rt, immExt: immExt};

endmodule

// ==== ctrlDecode.sv ====
`timescale 1ns/1ps

module ctrlDecode import mipsPkg::*; (
    input  instrWord instr,
    output ctrlSign  ctrl,
    output excFlags  exc
);

    logic [5:0] op;
    logic [5:0] funct;

    assign op = instr.rFormat.op;
    assign funct = instr.rFormat.funct;

    always_comb begin
        ctrl = CTRL_NOP;
        exc = '0;
        exc.eretInst = (instr == ERET_WORD);
        case (op)
            OP_SPECIAL: begin
                ctrl.regWen = 1'b1;
                case (funct)
                    FUN_AND: ctrl.alu = ALUOP_AND;
                    FUN_OR: ctrl.alu = ALUOP_OR;
                    FUN_XOR: ctrl.alu = ALUOP_XOR;
                    FUN_NOR: ctrl.alu = ALUOP_NOR;
                    FUN_SLT: ctrl.alu = ALUOP_SLT;
                    FUN_SLTU: ctrl.alu = ALUOP_SLTU;
                    FUN_ADD: ctrl.alu = ALUOP_ADD;
                    FUN_ADDU: ctrl.alu = ALUOP_ADDU;
                    FUN_SUB: ctrl.alu = ALUOP_SUB;
                    FUN_SUBU: ctrl.alu = ALUOP_SUBU;
                    FUN_SLLV: ctrl.alu = ALUOP_SLLV;
                    FUN_SRLV: begin
                        if (instr.rFormat.shamt[0]) begin  // rotrv
                            ctrl = CTRL_NOP;
                            exc.undefinedInst = 1'b1;
                        end else begin
                            ctrl.alu = ALUOP_SRLV;
                        end
                    end
                    FUN_SRAV: ctrl.alu = ALUOP_SRAV;
                    FUN_SLL, FUN_SRL, FUN_SRA: begin
                        ctrl.aluSelA = 1'b1;  // shift by shamt
                        ctrl.alu = (funct == FUN_SLL) ? ALUOP_SLL :
                                   (funct == FUN_SRL) ? ALUOP_SRL : ALUOP_SRA;
                        if (funct == FUN_SRL && instr.rFormat.rs[0]) begin  // rotr
                            ctrl = CTRL_NOP;
                            exc.undefinedInst = 1'b1;
                        end
                    end
                    FUN_MULT, FUN_MULTU, FUN_DIV, FUN_DIVU, FUN_MTHI, FUN_MTLO: begin
                        ctrl.regWen = 1'b0;
                        ctrl.hiloWrite = 1'b1;
                        ctrl.masterOnly = 1'b1;
                        case (funct)
                            FUN_MULT: ctrl.alu = ALUOP_MULT;
                            FUN_MULTU: ctrl.alu = ALUOP_MULTU;
                            FUN_DIV: ctrl.alu = ALUOP_DIV;
                            FUN_DIVU: ctrl.alu = ALUOP_DIVU;
                            FUN_MTHI: ctrl.alu = ALUOP_MTHI;
                            default: ctrl.alu = ALUOP_MTLO;
                        endcase
                    end
                    FUN_MFHI, FUN_MFLO: begin
                        ctrl.masterOnly = 1'b1;  // hilo read
                        ctrl.alu = (funct == FUN_MFHI) ? ALUOP_MFHI : ALUOP_MFLO;
                    end
                    FUN_JR: ctrl.regWen = 1'b0;
                    FUN_JALR: ctrl.alu = ALUOP_NOP;  // rd gets pc+8
                    FUN_SYSCALL, FUN_BREAK: begin
                        ctrl.regWen = 1'b0;
                        exc.specInst = 1'b1;
                        exc.syscallInst = (funct == FUN_SYSCALL);
                        exc.breakInst = (funct == FUN_BREAK);
                    end
                    default: begin
                        ctrl = CTRL_NOP;
                        exc.undefinedInst = 1'b1;
                    end
                endcase
            end
            OP_SPECIAL2: begin
                ctrl.masterOnly = 1'b1;
                case (funct)
                    FUN_MUL, FUN_CLO, FUN_CLZ: begin
                        ctrl.regWen = 1'b1;
                        ctrl.alu = (funct == FUN_MUL) ? ALUOP_MULT :
                                   (funct == FUN_CLO) ? ALUOP_CLO : ALUOP_CLZ;
                    end
                    FUN_MADD, FUN_MADDU, FUN_MSUB, FUN_MSUBU: begin
                        ctrl.hiloWrite = 1'b1;  // accumulate into hi/lo
                        ctrl.alu = (funct == FUN_MADD) ? ALUOP_MADD :
                                   (funct == FUN_MADDU) ? ALUOP_MADDU :
                                   (funct == FUN_MSUB) ? ALUOP_MSUB : ALUOP_MSUBU;
                    end
                    default: begin
                        ctrl = CTRL_NOP;
                        exc.undefinedInst = 1'b1;
                    end
                endcase
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                ctrl.alu = ALUOP_ADDU;  // address add
                ctrl.aluSelB = 1'b1;
                ctrl.memEn = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWen = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl.alu = ALUOP_ADDU;
                ctrl.aluSelB = 1'b1;
                ctrl.memEn = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.regWen = 1'b1;
                ctrl.aluSelB = 1'b1;
                case (op)
                    OP_ADDI: ctrl.alu = ALUOP_ADD;
                    OP_ADDIU: ctrl.alu = ALUOP_ADDU;
                    OP_SLTI: ctrl.alu = ALUOP_SLT;
                    OP_SLTIU: ctrl.alu = ALUOP_SLTU;
                    OP_ANDI: ctrl.alu = ALUOP_AND;
                    OP_ORI: ctrl.alu = ALUOP_OR;
                    OP_XORI: ctrl.alu = ALUOP_XOR;
                    default: ctrl.alu = ALUOP_LUI;
                endcase
            end
            OP_JAL: ctrl.regWen = 1'b1;  // r31 gets pc+8
            OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: ctrl = CTRL_NOP;
            OP_REGIMM: begin
                case (instr.iFormat.rt)
                    RT_BGEZAL, RT_BLTZAL: ctrl.regWen = 1'b1;
                    RT_BGEZ, RT_BLTZ: ctrl.regWen = 1'b0;
                    default: exc.undefinedInst = 1'b1;
                endcase
            end
            OP_COP0: begin
                exc.specInst = 1'b1;
                case (instr.rFormat.rs)
                    RS_MFC0: begin
                        ctrl.alu = ALUOP_MFC0;
                        ctrl.regWen = 1'b1;
                    end
                    RS_MTC0: begin
                        ctrl.alu = ALUOP_MTC0;
                        ctrl.cp0Write = 1'b1;
                    end
                    default: exc.undefinedInst = !exc.eretInst;
                endcase
            end
            default: exc.undefinedInst = 1'b1;
        endcase
    end

endmodule

// ==== instrLatch.sv ====
`timescale 1ns/1ps

module instrLatch import mipsPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  logic        wbAdr,
    input  logic [31:0] wbDat,
    output logic        wbAck,
    input  logic        pairTaken,
    output lanePair     lanes,
    output logic        pairValid
);

    logic        wbReq;
    logic        isCommit;
    logic        accept;
    logic [31:0] pendLane0;  // staged so a waiting pair stays intact

    assign wbReq = wbCyc && wbStb && !wbAck;  // no back-to-back ack
    assign isCommit = wbWe && (wbAdr == WB_ADR_LANE1);
    // commit stalls while the last pair is still waiting
    assign accept = wbReq && !(isCommit && pairValid);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbAck <= 1'b0;
            pairValid <= 1'b0;
        end else begin
            wbAck <= accept;
            if (accept && isCommit) begin
                pairValid <= 1'b1;
            end else if (pairTaken) begin
                pairValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && wbWe) begin
            if (wbAdr == WB_ADR_LANE0) begin
                pendLane0 <= wbDat;
            end else begin
                lanes[0] <= pendLane0;
                lanes[1] <= wbDat;
            end
        end
    end

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

    typedef logic [4:0] regIdx;
    typedef logic [7:0] aluOp;
    typedef logic [3:0] branchType;

    localparam int NUM_LANES = 2;
    localparam logic WB_ADR_LANE0 = 1'b0;
    localparam logic WB_ADR_LANE1 = 1'b1;  // writing this word commits the pair
    localparam regIdx LINK_REG = 5'd31;
    localparam logic [31:0] ERET_WORD = 32'h4200_0018;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J = 6'h02,
        OP_JAL = 6'h03, OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ = 6'h07,
        OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI = 6'h0c, OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f,
        OP_COP0 = 6'h10, OP_SPECIAL2 = 6'h1c,
        OP_LB = 6'h20, OP_LH = 6'h21, OP_LW = 6'h23, OP_LBU = 6'h24, OP_LHU = 6'h25,
        OP_SB = 6'h28, OP_SH = 6'h29, OP_SW = 6'h2b;

    // SPECIAL funct field
    localparam logic [5:0] FUN_SLL = 6'h00, FUN_SRL = 6'h02, FUN_SRA = 6'h03,
        FUN_SLLV = 6'h04, FUN_SRLV = 6'h06, FUN_SRAV = 6'h07,
        FUN_JR = 6'h08, FUN_JALR = 6'h09, FUN_SYSCALL = 6'h0c, FUN_BREAK = 6'h0d,
        FUN_MFHI = 6'h10, FUN_MTHI = 6'h11, FUN_MFLO = 6'h12, FUN_MTLO = 6'h13,
        FUN_MULT = 6'h18, FUN_MULTU = 6'h19, FUN_DIV = 6'h1a, FUN_DIVU = 6'h1b,
        FUN_ADD = 6'h20, FUN_ADDU = 6'h21, FUN_SUB = 6'h22, FUN_SUBU = 6'h23,
        FUN_AND = 6'h24, FUN_OR = 6'h25, FUN_XOR = 6'h26, FUN_NOR = 6'h27,
        FUN_SLT = 6'h2a, FUN_SLTU = 6'h2b;

    // SPECIAL2 funct field, overlaps the SPECIAL codes
    localparam logic [5:0] FUN_MADD = 6'h00, FUN_MADDU = 6'h01, FUN_MUL = 6'h02,
        FUN_MSUB = 6'h04, FUN_MSUBU = 6'h05, FUN_CLZ = 6'h20, FUN_CLO = 6'h21;

    localparam regIdx RT_BLTZ = 5'b00000, RT_BGEZ = 5'b00001;
    localparam regIdx RT_BLTZAL = 5'b10000, RT_BGEZAL = 5'b10001;
    localparam regIdx RS_MFC0 = 5'b00000, RS_MTC0 = 5'b00100;

    localparam aluOp ALUOP_NOP = 8'h00, ALUOP_AND = 8'h01, ALUOP_OR = 8'h02,
        ALUOP_XOR = 8'h03, ALUOP_NOR = 8'h04, ALUOP_SLT = 8'h05, ALUOP_SLTU = 8'h06,
        ALUOP_ADD = 8'h07, ALUOP_ADDU = 8'h08, ALUOP_SUB = 8'h09, ALUOP_SUBU = 8'h0a,
        ALUOP_SLL = 8'h0b, ALUOP_SLLV = 8'h0c, ALUOP_SRL = 8'h0d, ALUOP_SRLV = 8'h0e,
        ALUOP_SRA = 8'h0f, ALUOP_SRAV = 8'h10, ALUOP_MULT = 8'h11, ALUOP_MULTU = 8'h12,
        ALUOP_DIV = 8'h13, ALUOP_DIVU = 8'h14, ALUOP_MFHI = 8'h15, ALUOP_MFLO = 8'h16,
        ALUOP_MTHI = 8'h17, ALUOP_MTLO = 8'h18, ALUOP_CLO = 8'h19, ALUOP_CLZ = 8'h1a,
        ALUOP_MADD = 8'h1b, ALUOP_MADDU = 8'h1c, ALUOP_MSUB = 8'h1d, ALUOP_MSUBU = 8'h1e,
        ALUOP_LUI = 8'h1f, ALUOP_MFC0 = 8'h20, ALUOP_MTC0 = 8'h21;

    localparam branchType BT_NOP = 4'd0, BT_J = 4'd1, BT_JREG = 4'd2,
        BT_BEQ = 4'd3, BT_BNE = 4'd4, BT_BGTZ = 4'd5, BT_BLEZ = 4'd6,
        BT_BGEZ = 4'd7, BT_BLTZ = 4'd8;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            regIdx      rs;
            regIdx      rt;
            regIdx      rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFormat;
        struct packed {
            logic [5:0]  op;
            regIdx       rs;
            regIdx       rt;
            logic [15:0] imm;
        } iFormat;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } jFormat;
    } instrWord;

    typedef struct packed {
        aluOp alu;
        logic aluSelA;     // shamt as operand A
        logic aluSelB;     // immediate as operand B
        logic memEn;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic cp0Write;
        logic hiloWrite;
        logic regWen;
        logic masterOnly;  // may only issue in lane 0
    } ctrlSign;

    localparam ctrlSign CTRL_NOP = '0;

    typedef struct packed {
        logic undefinedInst;
        logic syscallInst;
        logic breakInst;
        logic eretInst;
        logic specInst;
    } excFlags;

    typedef struct packed {
        ctrlSign     ctrl;
        excFlags     exc;
        branchType   branch;
        logic        linkPc8;
        regIdx       regWaddr;
        regIdx       srcA;
        regIdx       srcB;
        logic [31:0] immExt;
    } decodedInstr;

    typedef instrWord [NUM_LANES-1:0] lanePair;
    typedef decodedInstr [NUM_LANES-1:0] packetPair;

endpackage
